// ==== source/cfg_pkg.sv ====
package cfg_pkg;

	// ============================================================
	// Bus widths and types
	// ============================================================
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int SEL_W = 4;			// One enable per byte lane
	localparam int VEC_W = 16;			// Interrupt vector / chain word

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [VEC_W-1:0] vec_t;

	// Config address layout: bus 27:22, device 21:17, function 16:14, word 7:2
	localparam int BUS_LSB = 22;
	localparam int DEV_LSB = 17;
	localparam int FUNC_LSB = 14;
	localparam int IDX_LSB = 2;
	localparam int BUS_W = 6;
	localparam int DEV_W = 5;
	localparam int FUNC_W = 3;
	localparam int IDX_W = 6;			// 64 header words

	// Header word index
	typedef enum logic [IDX_W-1:0] {
		REG_ID = 6'd0,			// Device / vendor ID
		REG_CMD_STAT = 6'd1,	// Status above command
		REG_CLASS = 6'd2,
		REG_MISC = 6'd3,		// Cache line, header type
		REG_BAR0 = 6'd4,
		REG_BAR1 = 6'd5,
		REG_BAR2 = 6'd6,
		REG_SUBSYS = 6'd11,
		REG_ROM = 6'd12,
		REG_IRQ_VEC0 = 6'd16,
		REG_IRQ_VEC1 = 6'd17,
		REG_IRQ_VEC2 = 6'd18,
		REG_IRQ_VEC3 = 6'd19
	} cfg_reg_e;

	// ============================================================
	// Fixed header contents
	// ============================================================
	localparam data_t CLASS_WORD = 32'h0380_0100;	// Display ctrl, other, progif 1, rev 0
	localparam data_t MISC_WORD = 32'h0000_0008;	// Type 0 header, cache line 8
	localparam data_t ROM_WORD = 32'hFFFF_FFF0;		// No expansion ROM decoded

	localparam logic [15:0] CMD_RESET = 16'h4003;
	localparam logic [15:0] CMD_FORCE_SET = 16'h0200;	// Fast back-to-back enable
	localparam logic [15:0] CMD_FORCE_CLR = 16'hF8B8;	// 15:11, 7, 5, 4, 3
	localparam logic [15:0] STAT_FORCE_SET = 16'h02A0;	// 9, 7, 5
	localparam logic [15:0] STAT_FORCE_CLR = 16'h0457;	// 10, 6, 4, 2:0

	localparam int HOLDOFF_W = 6;
	localparam logic [HOLDOFF_W-1:0] HOLDOFF_MAX = 6'd63;

	localparam int READ_LAT = 3;		// Request reg, read mux reg, output reg
	localparam int WRITE_LAT = 1;

endpackage

// ==== source/cfg_bus_if.sv ====
// Decoded register access, bus front end to header registers
interface cfg_bus_if;
	import cfg_pkg::*;

	logic hit;			// One-cycle strobe, access in progress
	logic we;			// Write when set
	sel_t sel;			// Byte enables of the request
	cfg_reg_e idx;		// Header word index
	data_t wdat;		// Write data
	data_t rdat;		// Read word, valid one cycle after hit

	// Front end drives the request side
	modport front (
		output hit,
		output we,
		output sel,
		output idx,
		output wdat,
		input rdat
	);

	// Register file consumes the request and answers with rdat
	modport regs (
		input hit,
		input we,
		input sel,
		input idx,
		input wdat,
		output rdat
	);

endinterface

// ==== source/cfg_bus_front.sv ====
module cfg_bus_front #(
	parameter logic [cfg_pkg::BUS_W-1:0] CFG_BUS = '0,
	parameter logic [cfg_pkg::DEV_W-1:0] CFG_DEVICE = '0,
	parameter logic [cfg_pkg::FUNC_W-1:0] CFG_FUNC = '0
) (
	input logic clk_i,
	input logic rst_i,
	input logic cs_i,
	input logic cyc_i,
	input logic we_i,
	input cfg_pkg::sel_t sel_i,
	input cfg_pkg::addr_t adr_i,
	input cfg_pkg::data_t dat_i,
	output logic ack_o,
	output cfg_pkg::data_t dat_o,
	cfg_bus_if.front bus
);
	import cfg_pkg::*;

	logic dev_hit;						// This function addressed
	logic [READ_LAT-1:0] rd_pipe;		// Read markers, one per stage
	logic [WRITE_LAT-1:0] wr_pipe;		// Write markers

	// ============================================================
	// Device select
	// ============================================================
	always_comb begin
		dev_hit = cs_i && cyc_i;
		dev_hit = dev_hit && (adr_i[BUS_LSB +: BUS_W] == CFG_BUS);
		dev_hit = dev_hit && (adr_i[DEV_LSB +: DEV_W] == CFG_DEVICE);
		dev_hit = dev_hit && (adr_i[FUNC_LSB +: FUNC_W] == CFG_FUNC);
		// Only the plain header window, bits between index and function must be zero
		dev_hit = dev_hit && (adr_i[FUNC_LSB-1 : IDX_LSB+IDX_W] == '0);
	end

	// Request register stage
	always_ff @(posedge clk_i) begin
		if (rst_i)
			bus.hit <= 1'b0;
		else
			bus.hit <= dev_hit;		// Master holds cyc one cycle, so this is a strobe
	end

	always_ff @(posedge clk_i) begin
		bus.we <= we_i;
		bus.sel <= sel_i;
		bus.idx <= cfg_reg_e'(adr_i[IDX_LSB +: IDX_W]);
		bus.wdat <= dat_i;
	end

	// ============================================================
	// Ack timing
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_pipe <= '0;
			wr_pipe <= '0;
		end else begin
			rd_pipe[0] <= dev_hit && !we_i;
			wr_pipe[0] <= dev_hit && we_i;
			for (int i = 1; i < READ_LAT; i++)
				rd_pipe[i] <= rd_pipe[i-1];		// Shift toward ack
			for (int i = 1; i < WRITE_LAT; i++)
				wr_pipe[i] <= wr_pipe[i-1];
		end
	end

	assign ack_o = rd_pipe[READ_LAT-1] | wr_pipe[WRITE_LAT-1];

	// Output register, zero outside read ack
	always_ff @(posedge clk_i) begin
		if (rst_i)
			dat_o <= '0;
		else if (rd_pipe[READ_LAT-2])
			dat_o <= bus.rdat;		// rdat valid in the stage before ack
		else
			dat_o <= '0;
	end

endmodule

// ==== source/cfg_header_regs.sv ====
module cfg_header_regs #(
	parameter logic [15:0] VENDOR_ID = 16'h0,
	parameter logic [15:0] DEVICE_ID = 16'h0,
	parameter logic [15:0] SUBSYS_VENDOR_ID = 16'h0,
	parameter logic [15:0] SUBSYS_ID = 16'h0,
	parameter cfg_pkg::data_t BAR0_INIT = 32'h1,
	parameter cfg_pkg::data_t BAR1_INIT = 32'h1,
	parameter cfg_pkg::data_t BAR2_INIT = 32'h1,
	parameter cfg_pkg::data_t BAR0_MASK = 32'h0,
	parameter cfg_pkg::data_t BAR1_MASK = 32'h0,
	parameter cfg_pkg::data_t BAR2_MASK = 32'h0
) (
	input logic clk_i,
	input logic rst_i,
	cfg_bus_if.regs bus,
	input logic [3:0] irq_i,
	input logic cyc_i,
	input cfg_pkg::addr_t adr_i,
	output cfg_pkg::vec_t irq_vect_o [4],
	output logic cs_bar0_o,
	output logic cs_bar1_o,
	output logic cs_bar2_o
);
	import cfg_pkg::*;

	localparam data_t [2:0] BAR_INIT = {BAR2_INIT, BAR1_INIT, BAR0_INIT};
	localparam data_t [2:0] BAR_MASK = {BAR2_MASK, BAR1_MASK, BAR0_MASK};
	localparam logic [7:0] ERR_BITS = 8'hF9;	// Status 15:11 and 8, in the top byte

	logic [15:0] cmd_reg;
	logic [15:0] stat_reg;			// Error bits only ever clear here
	data_t bar [3];
	logic [15:0] cmd_view;			// Command with forced bits
	logic [15:0] stat_view;
	logic [1:0] slot;				// BAR or vector slot of the index
	logic bar_sizing;				// All-ones full-word write
	logic [2:0] cs_bar;
	data_t rd_mux;

	assign slot = bus.idx[1:0];		// BAR0..2 at 4..6, vectors at 16..19
	assign bar_sizing = (&bus.sel) && (bus.wdat == '1);

	// ============================================================
	// Register writes
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmd_reg <= CMD_RESET;
			stat_reg <= '0;
			for (int b = 0; b < 3; b++)
				bar[b] <= BAR_INIT[b];
			for (int v = 0; v < 4; v++)
				irq_vect_o[v] <= '0;
		end else if (bus.hit && bus.we) begin
			case (bus.idx)
				REG_CMD_STAT: begin
					if (bus.sel[0]) cmd_reg[7:0] <= bus.wdat[7:0];
					if (bus.sel[1]) cmd_reg[15:8] <= bus.wdat[15:8];
					// Write one clears an error bit
					if (bus.sel[3])
						stat_reg[15:8] <= stat_reg[15:8] & ~(bus.wdat[31:24] & ERR_BITS);
				end
				REG_BAR0, REG_BAR1, REG_BAR2: begin
					if (bar_sizing)
						bar[slot] <= BAR_MASK[slot];	// Sizing read returns the mask
					else
						for (int n = 0; n < SEL_W; n++)
							if (bus.sel[n])
								bar[slot][8*n +: 8] <= bus.wdat[8*n +: 8];
				end
				REG_IRQ_VEC0, REG_IRQ_VEC1, REG_IRQ_VEC2, REG_IRQ_VEC3: begin
					if (&bus.sel)
						irq_vect_o[slot] <= bus.wdat[VEC_W-1:0];	// Full word only
				end
				default: ;
			endcase
		end
	end

	// Forced-bit views
	always_comb begin
		cmd_view = (cmd_reg | CMD_FORCE_SET) & ~CMD_FORCE_CLR;
		stat_view = (stat_reg | STAT_FORCE_SET) & ~STAT_FORCE_CLR;
		stat_view[3] = |irq_i;		// Interrupt pending
	end

	// ============================================================
	// Read multiplexer
	// ============================================================
	always_comb begin
		case (bus.idx)
			REG_ID: rd_mux = {DEVICE_ID, VENDOR_ID};
			REG_CMD_STAT: rd_mux = {stat_view, cmd_view};
			REG_CLASS: rd_mux = CLASS_WORD;
			REG_MISC: rd_mux = MISC_WORD;
			REG_BAR0, REG_BAR1, REG_BAR2: rd_mux = bar[slot];
			cfg_reg_e'(6'd7), cfg_reg_e'(6'd8), cfg_reg_e'(6'd9):
				rd_mux = '1;			// Unimplemented BARs read as ones
			REG_SUBSYS: rd_mux = {SUBSYS_ID, SUBSYS_VENDOR_ID};
			REG_ROM: rd_mux = ROM_WORD;
			REG_IRQ_VEC0, REG_IRQ_VEC1, REG_IRQ_VEC2, REG_IRQ_VEC3:
				rd_mux = {16'h0, irq_vect_o[slot]};
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_i)
		bus.rdat <= rd_mux;		// Second read stage

	// BAR chip selects, address matches base under mask
	always_comb begin
		for (int b = 0; b < 3; b++)
			cs_bar[b] = cyc_i && (((adr_i ^ bar[b]) & BAR_MASK[b]) == '0);
	end

	assign cs_bar0_o = cs_bar[0];
	assign cs_bar1_o = cs_bar[1];
	assign cs_bar2_o = cs_bar[2];

endmodule

// ==== source/irq_msg_gen.sv ====
module irq_msg_gen #(
	parameter int NIRQ = 4		// Lines in use, at most 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic [3:0] irq_i,
	input cfg_pkg::vec_t irq_vect_i [4],
	input cfg_pkg::vec_t chain_i,
	output cfg_pkg::vec_t chain_o
);
	import cfg_pkg::*;

	logic [NIRQ-1:0] irqf;						// Message pending per line
	logic [NIRQ-1:0] irq_set;
	logic [HOLDOFF_W-1:0] timer [NIRQ];		// Hold-off per line
	logic chain_empty;
	logic ins_valid;
	logic [1:0] ins_idx;						// Winning line

	assign chain_empty = (chain_i == '0);

	// Flag rises only when the hold-off has run out
	always_comb begin
		for (int k = 0; k < NIRQ; k++)
			irq_set[k] = irq_i[k] && (timer[k] == HOLDOFF_MAX) && !irqf[k];
	end

	// Fixed priority, lowest index wins
	always_comb begin
		ins_valid = 1'b0;
		ins_idx = 2'd0;
		for (int k = NIRQ-1; k >= 0; k--) begin
			if (irqf[k]) begin
				ins_valid = 1'b1;
				ins_idx = 2'(k);
			end
		end
	end

	// ============================================================
	// Chain stage and flags
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			chain_o <= '0;
			irqf <= '0;
		end else begin
			chain_o <= chain_i;		// Pass through by default
			irqf <= irqf | irq_set;
			if (chain_empty && ins_valid) begin
				chain_o <= irq_vect_i[ins_idx];		// Take the free slot
				irqf[ins_idx] <= 1'b0;
			end
		end
	end

	// Timer starts at zero on set and stays there until the message goes out
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < NIRQ; k++)
				timer[k] <= HOLDOFF_MAX;	// First request fires at once
		end else begin
			for (int k = 0; k < NIRQ; k++) begin
				if (irq_set[k] || irqf[k])
					timer[k] <= '0;
				else if (timer[k] != HOLDOFF_MAX)
					timer[k] <= timer[k] + 1'b1;
			end
		end
	end

endmodule

// ==== source/cfg_space_top.sv ====
module cfg_space_top #(
	parameter logic [cfg_pkg::BUS_W-1:0] CFG_BUS = 6'd0,
	parameter logic [cfg_pkg::DEV_W-1:0] CFG_DEVICE = 5'd1,
	parameter logic [cfg_pkg::FUNC_W-1:0] CFG_FUNC = 3'd0,
	parameter logic [15:0] VENDOR_ID = 16'hA5C1,
	parameter logic [15:0] DEVICE_ID = 16'h0C11,
	parameter logic [15:0] SUBSYS_VENDOR_ID = 16'hA5C1,
	parameter logic [15:0] SUBSYS_ID = 16'h0001,
	parameter cfg_pkg::data_t BAR0_INIT = 32'hD000_0000,
	parameter cfg_pkg::data_t BAR1_INIT = 32'hD010_0000,
	parameter cfg_pkg::data_t BAR2_INIT = 32'hD020_0000,
	parameter cfg_pkg::data_t BAR0_MASK = 32'hFFF0_0000,	// 1 MB window
	parameter cfg_pkg::data_t BAR1_MASK = 32'hFFFF_C000,	// 16 kB
	parameter cfg_pkg::data_t BAR2_MASK = 32'hFFFF_FF00,	// 256 B
	parameter int NIRQ = 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic cs_i,
	input logic cyc_i,
	input logic we_i,
	input cfg_pkg::sel_t sel_i,
	input cfg_pkg::addr_t adr_i,
	input cfg_pkg::data_t dat_i,
	output logic ack_o,
	output cfg_pkg::data_t dat_o,
	input logic [3:0] irq_i,
	input cfg_pkg::vec_t chain_i,
	output cfg_pkg::vec_t chain_o,
	output logic cs_bar0_o,
	output logic cs_bar1_o,
	output logic cs_bar2_o
);
	import cfg_pkg::*;

	vec_t irq_vect [4];			// Programmed vectors to the chain stage

	cfg_bus_if cfg_bus ();

	// ============================================================
	// Front end, header registers, interrupt messages
	// ============================================================
	cfg_bus_front #(
		.CFG_BUS(CFG_BUS),
		.CFG_DEVICE(CFG_DEVICE),
		.CFG_FUNC(CFG_FUNC)
	) u_front (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cs_i(cs_i),
		.cyc_i(cyc_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.ack_o(ack_o),
		.dat_o(dat_o),
		.bus(cfg_bus)
	);

	cfg_header_regs #(
		.VENDOR_ID(VENDOR_ID),
		.DEVICE_ID(DEVICE_ID),
		.SUBSYS_VENDOR_ID(SUBSYS_VENDOR_ID),
		.SUBSYS_ID(SUBSYS_ID),
		.BAR0_INIT(BAR0_INIT),
		.BAR1_INIT(BAR1_INIT),
		.BAR2_INIT(BAR2_INIT),
		.BAR0_MASK(BAR0_MASK),
		.BAR1_MASK(BAR1_MASK),
		.BAR2_MASK(BAR2_MASK)
	) u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.bus(cfg_bus),
		.irq_i(irq_i),			// Status bit 3
		.cyc_i(cyc_i),
		.adr_i(adr_i),
		.irq_vect_o(irq_vect),
		.cs_bar0_o(cs_bar0_o),
		.cs_bar1_o(cs_bar1_o),
		.cs_bar2_o(cs_bar2_o)
	);

	irq_msg_gen #(
		.NIRQ(NIRQ)
	) u_irq (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.irq_i(irq_i),
		.irq_vect_i(irq_vect),
		.chain_i(chain_i),
		.chain_o(chain_o)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Free-running testbench clock, 4 ns period
module tb_clock_gen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;		// Half period
	end

endmodule

// ==== verification/cfg_space_properties.sv ====
module cfg_space_properties #(
	parameter logic [cfg_pkg::BUS_W-1:0] CFG_BUS = '0,
	parameter logic [cfg_pkg::DEV_W-1:0] CFG_DEVICE = '0,
	parameter logic [cfg_pkg::FUNC_W-1:0] CFG_FUNC = '0
) (
	input logic clk_i,
	input logic rst_i,
	input logic cs_i,
	input logic cyc_i,
	input logic we_i,
	input cfg_pkg::addr_t adr_i,
	input logic ack_o,
	input cfg_pkg::data_t dat_o,
	input cfg_pkg::vec_t chain_i,
	input cfg_pkg::vec_t chain_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import cfg_pkg::*;

	logic addr_match;				// Bus, device, function and plain window
	logic rd_req;
	logic wr_req;
	logic unsel_req;				// Strobe that must stay unanswered
	logic rd_ack_bad = 1'b0;
	logic wr_ack_bad = 1'b0;
	logic ack_src_bad = 1'b0;
	logic unsel_bad = 1'b0;
	logic dat_idle_bad = 1'b0;
	logic reset_bad = 1'b0;
	logic chain_bad = 1'b0;
	logic any_fail;					// Sticky, watched by the testbench

	// Field positions 27:22, 21:17, 16:14, window bits 13:8
	assign addr_match = (adr_i[27:22] == CFG_BUS) && (adr_i[21:17] == CFG_DEVICE)
		&& (adr_i[16:14] == CFG_FUNC) && (adr_i[13:8] == 6'h00);
	assign rd_req = cs_i && cyc_i && !we_i && addr_match;
	assign wr_req = cs_i && cyc_i && we_i && addr_match;
	assign unsel_req = cs_i && cyc_i && !addr_match;

	// ============================================================
	// Ack timing and selection
	// ============================================================
	a_read_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(rd_req, 3) |-> ack_o)
		else begin
			rd_ack_bad = 1'b1;
			$error("read ack missing three cycles after the request");
		end

	a_write_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(wr_req, 1) |-> ack_o)
		else begin
			wr_ack_bad = 1'b1;
			$error("write ack missing one cycle after the request");
		end

	// Any ack must trace back to a request at the exact latency
	a_ack_source: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> ($past(rd_req, 3) || $past(wr_req, 1)))
		else begin
			ack_src_bad = 1'b1;
			$error("ack without a request at the fixed latency");
		end

	a_unselected: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> !($past(unsel_req, 1) || $past(unsel_req, 3)))
		else begin
			unsel_bad = 1'b1;
			$error("ack for an unselected request");
		end

	a_dat_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		!ack_o |-> (dat_o == '0))
		else begin
			dat_idle_bad = 1'b1;
			$error("read data not zero outside ack");
		end

	a_after_reset: assert property (@(posedge clk_i)
		$past(rst_i) |-> (!ack_o && (chain_o == '0)))
		else begin
			reset_bad = 1'b1;
			$error("ack or chain active after reset");
		end

	// ============================================================
	// Interrupt chain
	// ============================================================
	a_chain_pass: assert property (@(posedge clk_i) disable iff (rst_i)
		($past(chain_i) != '0) |-> (chain_o == $past(chain_i)))
		else begin
			chain_bad = 1'b1;
			$error("busy chain slot not passed through");
		end

	assign any_fail = rd_ack_bad | wr_ack_bad | ack_src_bad | unsel_bad
		| dat_idle_bad | reset_bad | chain_bad;

endmodule

// ==== verification/cfg_space_tb.sv ====
module cfg_space_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cfg_pkg::*;

	localparam logic [5:0] TB_BUS = 6'd5;
	localparam logic [4:0] TB_DEV = 5'd9;
	localparam logic [2:0] TB_FUNC = 3'd2;
	localparam logic [15:0] TB_VENDOR = 16'h1D6E;
	localparam logic [15:0] TB_DEVICE = 16'h7A31;
	localparam logic [15:0] TB_SUB_ID = 16'h0042;
	localparam data_t TB_BAR_INIT [3] = '{32'hC000_0000, 32'hC800_0000, 32'hCA00_0000};
	localparam data_t TB_BAR_MASK [3] = '{32'hFFF0_0000, 32'hFFFF_F000, 32'hFFFF_FFC0};
	localparam logic [15:0] CMD_SET_BITS = 16'h0200;	// Bit 9
	localparam logic [15:0] CMD_CLR_BITS = 16'hF8B8;	// 15:11, 7, 5, 4, 3
	localparam logic [15:0] STAT_IDLE = 16'h02A0;		// Status with no irq and no errors
	localparam int TIMEOUT = 300;						// Cycles per wait

	logic clk;
	logic rst;
	logic cs;
	logic cyc;
	logic we;
	sel_t sel;
	addr_t adr;
	data_t wdat;
	logic ack;
	data_t rdat;
	logic [3:0] irq;
	vec_t chain_in;
	vec_t chain_out;
	logic [2:0] cs_bar;
	vec_t vect [4];				// Programmed vectors
	logic [15:0] cmd_model;		// Stored command bits
	int cycle_cnt = 0;

	tb_clock_gen u_clk (.clk_o(clk));

	cfg_space_top #(
		.CFG_BUS(TB_BUS), .CFG_DEVICE(TB_DEV), .CFG_FUNC(TB_FUNC),
		.VENDOR_ID(TB_VENDOR), .DEVICE_ID(TB_DEVICE),
		.SUBSYS_VENDOR_ID(TB_VENDOR), .SUBSYS_ID(TB_SUB_ID),
		.BAR0_INIT(TB_BAR_INIT[0]), .BAR1_INIT(TB_BAR_INIT[1]), .BAR2_INIT(TB_BAR_INIT[2]),
		.BAR0_MASK(TB_BAR_MASK[0]), .BAR1_MASK(TB_BAR_MASK[1]), .BAR2_MASK(TB_BAR_MASK[2]),
		.NIRQ(4)
	) dut_i (
		.clk_i(clk), .rst_i(rst), .cs_i(cs), .cyc_i(cyc), .we_i(we), .sel_i(sel),
		.adr_i(adr), .dat_i(wdat), .ack_o(ack), .dat_o(rdat), .irq_i(irq),
		.chain_i(chain_in), .chain_o(chain_out),
		.cs_bar0_o(cs_bar[0]), .cs_bar1_o(cs_bar[1]), .cs_bar2_o(cs_bar[2])
	);

	bind cfg_space_top cfg_space_properties #(
		.CFG_BUS(CFG_BUS), .CFG_DEVICE(CFG_DEVICE), .CFG_FUNC(CFG_FUNC)
	) u_props (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .cyc_i(cyc_i), .we_i(we_i),
		.adr_i(adr_i), .ack_o(ack_o), .dat_o(dat_o), .chain_i(chain_i), .chain_o(chain_o)
	);

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	always @(negedge clk) begin
		if (dut_i.u_props.any_fail)
			abort_run("a bound assertion on ack, select or chain behavior failed");
	end

	// Config address of a header word in this function
	function automatic addr_t hdr_addr(input logic [5:0] idx);
		return {4'h0, TB_BUS, TB_DEV, TB_FUNC, 6'h00, idx, 2'b00};
	endfunction

	function automatic logic [15:0] cmd_expect(input logic [15:0] c);
		return (c | CMD_SET_BITS) & ~CMD_CLR_BITS;
	endfunction

	// One-cycle strobe, then wait for ack at the falling edges
	task automatic bus_access(input logic write, input addr_t a, input data_t d,
			input sel_t s, output data_t q);
		int waited;
		@(negedge clk);
		cs = 1'b1;
		cyc = 1'b1;
		we = write;
		adr = a;
		wdat = d;
		sel = s;
		@(negedge clk);
		cs = 1'b0;
		cyc = 1'b0;
		we = 1'b0;
		waited = 0;
		while (!ack) begin
			if (waited == TIMEOUT)
				abort_run("no ack_o from the DUT within the timeout");
			@(negedge clk);
			waited++;
		end
		q = rdat;			// dat_o valid with the ack
	endtask

	task automatic write_reg(input logic [5:0] idx, input data_t d, input sel_t s);
		data_t unused;
		bus_access(1'b1, hdr_addr(idx), d, s, unused);
	endtask

	task automatic check_reg(input logic [5:0] idx, input data_t exp, input string what);
		data_t got;
		bus_access(1'b0, hdr_addr(idx), '0, 4'hF, got);
		if (got !== exp)
			abort_run($sformatf("error dat_o (%s) = %h, expected %h", what, got, exp));
	endtask

	// Request that must stay unanswered past the read latency
	task automatic probe_unselected(input addr_t a, input string what);
		@(negedge clk);
		cs = 1'b1;
		cyc = 1'b1;
		adr = a;
		@(negedge clk);
		cs = 1'b0;
		cyc = 1'b0;
		repeat (6) begin
			if (ack)
				abort_run($sformatf("ack_o answered a request with %s", what));
			@(negedge clk);
		end
	endtask

	task automatic wait_chain(input vec_t v, input string what);
		int waited;
		waited = 0;
		while (chain_out !== v) begin
			if (waited == TIMEOUT)
				abort_run($sformatf("chain_o never showed the %s", what));
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic wait_chain_busy(output vec_t v);
		int waited;
		waited = 0;
		while (chain_out === '0) begin
			if (waited == TIMEOUT)
				abort_run("chain_o stayed empty with interrupt lines raised");
			@(negedge clk);
			waited++;
		end
		v = chain_out;
	endtask

	initial begin
		data_t d;
		sel_t s;
		data_t base;
		data_t off;
		vec_t first;
		int t_first;
		int t_second;
		cs = 1'b0;
		cyc = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		wdat = '0;
		irq = '0;
		chain_in = '0;
		rst = 1'b1;
		void'($urandom(32'hC5D8));
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// ============================================================
		// Reset values
		// ============================================================
		check_reg(REG_ID, {TB_DEVICE, TB_VENDOR}, "ID word");
		check_reg(REG_CMD_STAT, {STAT_IDLE, 16'h0203}, "command/status");
		irq = 4'b0001;
		check_reg(REG_CMD_STAT, {STAT_IDLE | 16'h0008, 16'h0203}, "status with irq");
		irq = '0;
		for (int b = 0; b < 3; b++)
			check_reg(6'(4 + b), TB_BAR_INIT[b], "BAR default");
		check_reg(REG_CLASS, 32'h0380_0100, "class word");
		check_reg(REG_MISC, 32'h0000_0008, "misc word");
		check_reg(REG_ROM, 32'hFFFF_FFF0, "ROM word");
		check_reg(REG_SUBSYS, {TB_SUB_ID, TB_VENDOR}, "subsystem IDs");
		check_reg(6'd8, 32'hFFFF_FFFF, "unused BAR slot");
		check_reg(6'd30, 32'h0, "unlisted word");

		// Command bytes per enable with forced bits on read
		cmd_model = 16'h4003;
		repeat (10) begin
			d = $urandom;
			s = 4'($urandom);
			write_reg(REG_CMD_STAT, d, s);
			if (s[0])
				cmd_model[7:0] = d[7:0];
			if (s[1])
				cmd_model[15:8] = d[15:8];
			check_reg(REG_CMD_STAT, {STAT_IDLE, cmd_expect(cmd_model)}, "command write");
		end
		write_reg(REG_CMD_STAT, 32'hF900_0000, 4'b1000);	// Write one to error bits
		check_reg(REG_CMD_STAT, {STAT_IDLE, cmd_expect(cmd_model)}, "status error clear");

		// ============================================================
		// BAR sizing and decode
		// ============================================================
		for (int b = 0; b < 3; b++) begin
			write_reg(6'(4 + b), 32'hFFFF_FFFF, 4'hF);
			check_reg(6'(4 + b), TB_BAR_MASK[b], "BAR sizing");
			base = $urandom & TB_BAR_MASK[b];
			write_reg(6'(4 + b), base, 4'hF);
			check_reg(6'(4 + b), base, "BAR base");
			off = $urandom & ~TB_BAR_MASK[b];		// Offset inside the window
			@(negedge clk);
			cyc = 1'b1;
			adr = base | off;
			#1;
			if (cs_bar[b] !== 1'b1)
				abort_run($sformatf("error cs_bar%0d_o = %h, expected %h", b, cs_bar[b], 1'b1));
			@(negedge clk);
			adr = base ^ (TB_BAR_MASK[b] & ~(TB_BAR_MASK[b] - 1));	// Lowest masked bit
			#1;
			if (cs_bar[b] !== 1'b0)
				abort_run($sformatf("error cs_bar%0d_o = %h, expected %h", b, cs_bar[b], 1'b0));
			@(negedge clk);
			cyc = 1'b0;
		end

		// Selection misses
		probe_unselected(hdr_addr(REG_ID) ^ (32'h1 << 14), "a wrong function number");
		probe_unselected(hdr_addr(REG_ID) | 32'h0000_0100, "address bit 8 set");
		check_reg(REG_ID, {TB_DEVICE, TB_VENDOR}, "ID after misses");

		// ============================================================
		// Interrupt messages
		// ============================================================
		for (int k = 0; k < 4; k++) begin
			vect[k] = {4'(k + 1), 12'($urandom)};		// Never zero
			write_reg(6'(16 + k), {16'h0, vect[k]}, 4'hF);
			check_reg(6'(16 + k), {16'h0, vect[k]}, "interrupt vector");
		end
		irq = 4'b0010;
		wait_chain(vect[1], "line 1 vector");
		irq = '0;
		wait_chain('0, "empty slot after line 1");

		irq = 4'b1100;				// Two lines together
		wait_chain_busy(first);
		if (first !== vect[2])
			abort_run($sformatf("error chain_o = %h, expected %h", first, vect[2]));
		wait_chain(vect[3], "line 3 vector");
		irq = '0;

		// Held line with the slot busy for a while first
		irq = 4'b0001;
		chain_in = 16'hBEEF;
		repeat (10) @(negedge clk);
		chain_in = '0;
		wait_chain(vect[0], "line 0 vector");
		t_first = cycle_cnt;
		wait_chain('0, "empty slot after insertion");
		wait_chain(vect[0], "repeated line 0 vector");
		t_second = cycle_cnt;
		if (t_second - t_first < 64)
			abort_run($sformatf("error chain_o insertion gap = %h, expected at least %h",
				t_second - t_first, 64));
		irq = '0;
		repeat (4) @(negedge clk);

		if (dut_i.u_props.any_fail)
			abort_run("a bound assertion failed before the end of the run");
		else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
source/cfg_pkg.sv
source/cfg_bus_if.sv
source/cfg_bus_front.sv
source/cfg_header_regs.sv
source/irq_msg_gen.sv
source/cfg_space_top.sv
verification/tb_clock_gen.sv
verification/cfg_space_properties.sv
verification/cfg_space_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cfg_space_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
